/* design/psg_consts.svh */
`ifndef PSG_CONSTS_SVH
`define PSG_CONSTS_SVH

// Generator instances on the bus
`define PSG_NUM_CHIPS 2

// Register file depth per chip
`define PSG_NUM_REGS 16

// Enable divider terminal counts
`define PSG_DIV_6MHZ 7
`define PSG_DIV_4MHZ 11

// Register map
`define PSG_REG_MIXER 7
`define PSG_REG_VOL_A 8
`define PSG_REG_PORT_A 14
`define PSG_REG_PORT_B 15

// Mixer bits 6 and 7 set port direction
`define PSG_DIR_BIT_A 6
`define PSG_DIR_BIT_B 7

`endif

/* design/psgPkg.sv */
package psgPkg;

	// Board variants sharing this block
	typedef enum logic [1:0] {
		hwNinjakun = 2'd0,
		hwRaiders5 = 2'd1,
		hwNova2001 = 2'd2
	} hwType;

	// Tone channel number, 0 to 2
	typedef logic [1:0] chanIdx;

	// Register file index
	typedef logic [3:0] regIdx;

	// One channel level, volume in both nibbles
	typedef logic [7:0] chanLevel;

	// Widened mixer output
	typedef logic [15:0] mixSample;

endpackage

/* design/psgBusIf.sv */
interface psgBusIf;

	logic sel;
	logic addrPort;
	logic wr;
	logic [7:0] wdata;
	logic [7:0] rdata;
	logic [7:0] portInA;
	logic [7:0] portInB;

	modport decoder (
		output sel,
		output addrPort,
		output wr,
		output wdata,
		output portInA,
		output portInB,
		input rdata
	);

	modport chip (
		input sel,
		input addrPort,
		input wr,
		input wdata,
		input portInA,
		input portInB,
		output rdata
	);

endinterface

/* design/psgClockEnable.sv */
`include "psg_consts.svh"

module psgClockEnable (
	input logic MCLK,
	input logic rstN,
	input psgPkg::hwType hwSel,
	output logic ena
);

	logic [3:0] divCnt;
	logic [3:0] divLast;

	// 6 MHz chips on 48 MHz clock, 4 MHz on Nova2001
	always_comb begin
		if (hwSel == psgPkg::hwNova2001)
			divLast = 4'(`PSG_DIV_4MHZ);
		else
			divLast = 4'(`PSG_DIV_6MHZ);
	end

	always_ff @(posedge MCLK) begin
		if (!rstN) begin
			divCnt <= '0;
			ena <= 1'b0;
		end else begin
			ena <= (divCnt == 4'd0);
			divCnt <= (divCnt >= divLast) ? 4'd0 : divCnt + 4'd1;
		end
	end

	assert property (@(posedge MCLK) disable iff (!rstN) ena |=> !ena);

endmodule

/* design/psgBusDecoder.sv */
`include "psg_consts.svh"

module psgBusDecoder (
	input psgPkg::hwType hwSel,
	input logic [1:0] adr,
	input logic cs,
	input logic wr,
	input logic vblk,
	input logic [7:0] id,
	input logic [7:0] dsw1,
	input logic [7:0] dsw2,
	input logic [7:0] ctr1,
	input logic [7:0] ctr2,
	output logic [7:0] od,
	psgBusIf.decoder chipBus [`PSG_NUM_CHIPS]
);

	logic isNova;
	logic chipNum;
	logic addrPort;

	assign isNova = (hwSel == psgPkg::hwNova2001);

	// Nova2001 swaps the roles of the two address lines
	assign chipNum = isNova ? adr[0] : adr[1];
	assign addrPort = isNova ? adr[1] : ~adr[0];

	for (genvar i = 0; i < `PSG_NUM_CHIPS; i++) begin : genAccess
		assign chipBus[i].sel = cs && (chipNum == 1'(i));
		assign chipBus[i].addrPort = addrPort;
		assign chipBus[i].wr = wr;
		assign chipBus[i].wdata = id;
	end

	// Input port bytes per board
	always_comb begin
		case (hwSel)
			psgPkg::hwRaiders5: begin
				chipBus[0].portInA = {~vblk, ctr1[6:0]};
				chipBus[0].portInB = ctr2;
				chipBus[1].portInA = dsw1;
				chipBus[1].portInB = dsw2;
			end
			psgPkg::hwNova2001: begin
				chipBus[0].portInA = dsw1;
				chipBus[0].portInB = dsw2;
				chipBus[1].portInA = dsw1;
				chipBus[1].portInB = dsw2;
			end
			default: begin
				// Ninjakun leaves chip 1 ports unconnected
				chipBus[0].portInA = dsw1;
				chipBus[0].portInB = dsw2;
				chipBus[1].portInA = 8'h00;
				chipBus[1].portInB = 8'h00;
			end
		endcase
	end

	assign od = chipNum ? chipBus[1].rdata : chipBus[0].rdata;

	always_comb begin
		assert final (!(chipBus[0].sel && chipBus[1].sel));
	end

endmodule

/* design/psgToneChip.sv */
`include "psg_consts.svh"

module psgToneChip (
	input logic MCLK,
	input logic rstN,
	input logic ena,
	psgBusIf.chip bus,
	output psgPkg::chanLevel level,
	output psgPkg::chanIdx chan,
	output logic [7:0] portOutA,
	output logic [7:0] portOutB
);

	psgPkg::regIdx addrLatch;
	logic [7:0] regs [`PSG_NUM_REGS];
	logic [11:0] toneCnt [3];
	logic [11:0] period [3];
	logic [2:0] square;
	psgPkg::chanLevel chLevel [3];
	psgPkg::chanIdx nextChan;
	logic [7:0] mixerReg;
	logic dirOutA;
	logic dirOutB;

	assign mixerReg = regs[`PSG_REG_MIXER];
	assign dirOutA = mixerReg[`PSG_DIR_BIT_A];
	assign dirOutB = mixerReg[`PSG_DIR_BIT_B];

	// Address latch and register file
	always_ff @(posedge MCLK) begin
		if (!rstN) begin
			addrLatch <= '0;
			for (int r = 0; r < `PSG_NUM_REGS; r++)
				regs[r] <= 8'h00;
		end else if (bus.sel && bus.wr) begin
			if (bus.addrPort)
				addrLatch <= bus.wdata[3:0];
			else
				regs[addrLatch] <= bus.wdata;
		end
	end

	// Ports set as inputs read back the pins
	always_comb begin
		if (addrLatch == 4'(`PSG_REG_PORT_A) && !dirOutA)
			bus.rdata = bus.portInA;
		else if (addrLatch == 4'(`PSG_REG_PORT_B) && !dirOutB)
			bus.rdata = bus.portInB;
		else
			bus.rdata = regs[addrLatch];
	end

	assign portOutA = dirOutA ? regs[`PSG_REG_PORT_A] : 8'h00;
	assign portOutB = dirOutB ? regs[`PSG_REG_PORT_B] : 8'h00;

	// Period from fine and coarse register pairs 0/1 2/3 4/5
	always_comb begin
		for (int c = 0; c < 3; c++)
			period[c] = {regs[2 * c + 1][3:0], regs[2 * c]};
	end

	always_ff @(posedge MCLK) begin
		if (!rstN) begin
			square <= '0;
			for (int c = 0; c < 3; c++)
				toneCnt[c] <= '0;
		end else if (ena) begin
			for (int c = 0; c < 3; c++) begin
				if (mixerReg[c]) begin
					// Tone off holds the output high
					square[c] <= 1'b1;
					toneCnt[c] <= '0;
				end else if (toneCnt[c] >= period[c]) begin
					square[c] <= ~square[c];
					toneCnt[c] <= '0;
				end else begin
					toneCnt[c] <= toneCnt[c] + 12'd1;
				end
			end
		end
	end

	always_comb begin
		for (int c = 0; c < 3; c++) begin
			if (square[c])
				chLevel[c] = {2{regs[`PSG_REG_VOL_A + c][3:0]}};
			else
				chLevel[c] = 8'h00;
		end
	end

	assign nextChan = (chan == 2'd2) ? 2'd0 : chan + 2'd1;

	// One channel per enable tick
	always_ff @(posedge MCLK) begin
		if (!rstN) begin
			chan <= '0;
			level <= '0;
		end else if (ena) begin
			chan <= nextChan;
			level <= chLevel[nextChan];
		end
	end

	assert property (@(posedge MCLK) disable iff (!rstN) chan != 2'd3);

endmodule

/* design/psgMixer.sv */
`include "psg_consts.svh"

module psgMixer (
	input logic MCLK,
	input logic rstN,
	input psgPkg::chanLevel level [`PSG_NUM_CHIPS],
	input psgPkg::chanIdx chan [`PSG_NUM_CHIPS],
	output psgPkg::mixSample sndOut
);

	psgPkg::chanLevel chLevel [`PSG_NUM_CHIPS][3];
	logic [11:0] mixSum;

	// Demultiplex each chip's sample stream
	always_ff @(posedge MCLK) begin
		if (!rstN) begin
			for (int k = 0; k < `PSG_NUM_CHIPS; k++)
				for (int c = 0; c < 3; c++)
					chLevel[k][c] <= '0;
		end else begin
			for (int k = 0; k < `PSG_NUM_CHIPS; k++)
				if (chan[k] != 2'd3)
					chLevel[k][chan[k]] <= level[k];
		end
	end

	always_comb begin
		mixSum = '0;
		for (int k = 0; k < `PSG_NUM_CHIPS; k++)
			for (int c = 0; c < 3; c++)
				mixSum = mixSum + 12'(chLevel[k][c]);
	end

	// Low nibble repeated to fill 16 bits
	always_ff @(posedge MCLK) begin
		if (!rstN)
			sndOut <= '0;
		else
			sndOut <= {mixSum, mixSum[3:0]};
	end

endmodule

/* design/psgSound.sv */
`include "psg_consts.svh"

module psgSound (
	input logic MCLK,
	input logic rstN,
	input logic [1:0] hwSel,
	input logic [1:0] adr,
	input logic cs,
	input logic wr,
	input logic [7:0] id,
	output logic [7:0] od,
	input logic [7:0] dsw1,
	input logic [7:0] dsw2,
	input logic [7:0] ctr1,
	input logic [7:0] ctr2,
	input logic vblk,
	output logic [7:0] scrPx,
	output logic [7:0] scrPy,
	output logic [15:0] sndOut
);

	psgPkg::hwType board;
	logic ena;
	psgPkg::chanLevel level [`PSG_NUM_CHIPS];
	psgPkg::chanIdx chan [`PSG_NUM_CHIPS];
	logic [7:0] portOutA [`PSG_NUM_CHIPS];
	logic [7:0] portOutB [`PSG_NUM_CHIPS];

	psgBusIf chipBus [`PSG_NUM_CHIPS] ();

	assign board = psgPkg::hwType'(hwSel);

	psgClockEnable clkEna_i (.MCLK(MCLK), .rstN(rstN), .hwSel(board), .ena(ena));

	psgBusDecoder decoder_i (
		.hwSel(board), .adr(adr), .cs(cs), .wr(wr), .vblk(vblk),
		.id(id), .dsw1(dsw1), .dsw2(dsw2), .ctr1(ctr1), .ctr2(ctr2),
		.od(od), .chipBus(chipBus)
	);

	for (genvar i = 0; i < `PSG_NUM_CHIPS; i++) begin : genChip
		psgToneChip chip_i (
			.MCLK(MCLK), .rstN(rstN), .ena(ena), .bus(chipBus[i]),
			.level(level[i]), .chan(chan[i]),
			.portOutA(portOutA[i]), .portOutB(portOutB[i])
		);
	end

	psgMixer mixer_i (.MCLK(MCLK), .rstN(rstN), .level(level), .chan(chan), .sndOut(sndOut));

	// Scroll registers live on chip 0 only on Nova2001
	assign scrPx = (board == psgPkg::hwNova2001) ? portOutA[0] : portOutA[1];
	assign scrPy = (board == psgPkg::hwNova2001) ? portOutB[0] : portOutB[1];

endmodule

/* verif/psgSoundTb.sv */
`include "psg_consts.svh"

module psgSoundTb;

	typedef enum {actWrAddr, actWrData, actRead, actSound, actScrX, actScrY} actKind;

	typedef struct {
		string name;
		psgPkg::hwType board;
		actKind act;
		logic [1:0] adr;
		logic [7:0] data;
		logic [15:0] expected;
	} stepEntry;

	logic MCLK = 1'b0;
	logic rstN;
	psgPkg::hwType hwSel;
	logic [1:0] adr;
	logic cs;
	logic wr;
	logic [7:0] id;
	logic [7:0] od;
	logic [7:0] dsw1;
	logic [7:0] dsw2;
	logic [7:0] ctr1;
	logic [7:0] ctr2;
	logic vblk;
	logic [7:0] scrPx;
	logic [7:0] scrPy;
	psgPkg::mixSample sndOut;

	stepEntry steps[$];
	int cycles = 0;
	int cycleLimit;

	psgSound dut_i (
		.MCLK(MCLK), .rstN(rstN), .hwSel(hwSel), .adr(adr), .cs(cs), .wr(wr),
		.id(id), .od(od), .dsw1(dsw1), .dsw2(dsw2), .ctr1(ctr1), .ctr2(ctr2),
		.vblk(vblk), .scrPx(scrPx), .scrPy(scrPy), .sndOut(sndOut)
	);

	always #4 MCLK = ~MCLK;

	always @(posedge MCLK) begin
		cycles++;
		if (cycles > cycleLimit) begin
			$display("Run did not finish within %0d cycles", cycleLimit);
			$display("test failed");
			$fatal(1);
		end
	end

	task automatic checkByte(input string name, input logic [7:0] expected,
			input logic [7:0] actual);
		if (actual !== expected) begin
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
			$display("test failed");
			$fatal(1);
		end
	endtask

	task automatic checkSample(input string name, input psgPkg::mixSample expected,
			input psgPkg::mixSample actual);
		if (actual !== expected) begin
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
			$display("test failed");
			$fatal(1);
		end
	endtask

	// Address map: Nova2001 swaps the two address lines
	function automatic logic [1:0] busAdr(psgPkg::hwType board, int chip, bit toLatch);
		if (board == psgPkg::hwNova2001)
			return {toLatch, 1'(chip)};
		return {1'(chip), !toLatch};
	endfunction

	// Input routing table, port 0 is A
	function automatic logic [7:0] portByte(psgPkg::hwType board, int chip, int port);
		if (board == psgPkg::hwRaiders5 && chip == 0)
			return port == 0 ? {~vblk, ctr1[6:0]} : ctr2;
		if (board == psgPkg::hwNinjakun && chip == 1)
			return 8'h00;
		return port == 0 ? dsw1 : dsw2;
	endfunction

	task automatic addStep(string name, psgPkg::hwType board, actKind act, logic [1:0] a,
			logic [7:0] data, logic [15:0] expected);
		steps.push_back('{name, board, act, a, data, expected});
	endtask

	task automatic writeReg(string name, psgPkg::hwType board, int chip, int r,
			logic [7:0] data);
		addStep(name, board, actWrAddr, busAdr(board, chip, 1'b1), 8'(r), '0);
		addStep(name, board, actWrData, busAdr(board, chip, 1'b0), data, '0);
	endtask

	task automatic readReg(string name, psgPkg::hwType board, int chip, int r,
			logic [7:0] expected);
		addStep(name, board, actWrAddr, busAdr(board, chip, 1'b1), 8'(r), '0);
		addStep(name, board, actRead, busAdr(board, chip, 1'b0), 8'h00, 16'(expected));
	endtask

	// Tones off, so every channel sits at its doubled volume
	task automatic soundCase(string name, psgPkg::hwType board, logic [3:0] vols [6]);
		logic [11:0] sum;
		sum = '0;
		for (int k = 0; k < 6; k++) begin
			writeReg(name, board, k / 3, `PSG_REG_VOL_A + k % 3, {4'h0, vols[k]});
			sum = sum + 12'({vols[k], vols[k]});
		end
		addStep(name, board, actSound, 2'b00, 8'h00, {sum, sum[3:0]});
	endtask

	initial begin
		psgPkg::hwType boards [3];
		string tag;
		boards = '{psgPkg::hwNinjakun, psgPkg::hwRaiders5, psgPkg::hwNova2001};
		void'($urandom(4928));
		rstN = 1'b0;
		hwSel = psgPkg::hwNinjakun;
		adr = 2'b00;
		cs = 1'b0;
		wr = 1'b0;
		id = 8'h00;
		dsw1 = 8'($urandom);
		dsw2 = 8'($urandom);
		ctr1 = 8'($urandom);
		ctr2 = 8'($urandom);
		vblk = 1'($urandom);

		// Reset state, ports are still inputs so skip 14 and 15
		for (int c = 0; c < 2; c++)
			for (int r = 0; r < `PSG_REG_PORT_A; r++)
				readReg($sformatf("reset chip%0d reg%0d", c, r), boards[0], c, r, 8'h00);
		addStep("reset scrPx", boards[0], actScrX, 2'b00, 8'h00, '0);
		addStep("reset scrPy", boards[0], actScrY, 2'b00, 8'h00, '0);
		addStep("reset sndOut", boards[0], actSound, 2'b00, 8'h00, '0);

		foreach (boards[b]) begin
			tag = boards[b].name();
			for (int c = 0; c < 2; c++) begin
				writeReg({"rb ", tag}, boards[b], c, 1, 8'h5A ^ 8'(b * 16 + c));
				writeReg({"rb ", tag}, boards[b], c, 12, 8'hC3 ^ 8'(b * 32 + c * 3));
			end
			for (int c = 0; c < 2; c++) begin
				readReg({"rb ", tag, " reg1"}, boards[b], c, 1, 8'h5A ^ 8'(b * 16 + c));
				readReg({"rb ", tag, " reg12"}, boards[b], c, 12, 8'hC3 ^ 8'(b * 32 + c * 3));
			end
			for (int c = 0; c < 2; c++) begin
				readReg($sformatf("inA %s chip%0d", tag, c), boards[b], c,
					`PSG_REG_PORT_A, portByte(boards[b], c, 0));
				readReg($sformatf("inB %s chip%0d", tag, c), boards[b], c,
					`PSG_REG_PORT_B, portByte(boards[b], c, 1));
			end
		end

		// Scroll source is chip 1, then chip 0 on Nova2001
		writeReg("scroll r5", boards[1], 1, `PSG_REG_MIXER, 8'hC0);
		writeReg("scroll r5", boards[1], 1, `PSG_REG_PORT_A, 8'h6D);
		writeReg("scroll r5", boards[1], 1, `PSG_REG_PORT_B, 8'hB2);
		addStep("scrPx r5", boards[1], actScrX, 2'b00, 8'h00, 16'h006D);
		addStep("scrPy r5", boards[1], actScrY, 2'b00, 8'h00, 16'h00B2);
		writeReg("scroll nova", boards[2], 0, `PSG_REG_MIXER, 8'hC0);
		writeReg("scroll nova", boards[2], 0, `PSG_REG_PORT_A, 8'h3C);
		writeReg("scroll nova", boards[2], 0, `PSG_REG_PORT_B, 8'h96);
		addStep("scrPx nova", boards[2], actScrX, 2'b00, 8'h00, 16'h003C);
		addStep("scrPy nova", boards[2], actScrY, 2'b00, 8'h00, 16'h0096);
		addStep("scrPx ninja", boards[0], actScrX, 2'b00, 8'h00, 16'h006D);
		readReg("outA ninja", boards[0], 1, `PSG_REG_PORT_A, 8'h6D);

		writeReg("tones off", boards[1], 0, `PSG_REG_MIXER, 8'hC7);
		writeReg("tones off", boards[1], 1, `PSG_REG_MIXER, 8'hC7);
		soundCase("sound r5", boards[1], '{4'd3, 4'd5, 4'd9, 4'd15, 4'd1, 4'd7});
		soundCase("sound nova", boards[2], '{4'd2, 4'd4, 4'd6, 4'd8, 4'd10, 4'd12});
		cycleLimit = steps.size() * 60;

		repeat (3) @(posedge MCLK);
		#1;
		rstN = 1'b1;

		foreach (steps[i]) begin
			@(posedge MCLK);
			#1;
			hwSel = steps[i].board;
			adr = steps[i].adr;
			id = steps[i].data;
			cs = steps[i].act inside {actWrAddr, actWrData, actRead};
			wr = steps[i].act inside {actWrAddr, actWrData};
			case (steps[i].act)
				actRead: begin
					#2;
					checkByte(steps[i].name, steps[i].expected[7:0], od);
				end
				actScrX: begin
					#2;
					checkByte(steps[i].name, steps[i].expected[7:0], scrPx);
				end
				actScrY: begin
					#2;
					checkByte(steps[i].name, steps[i].expected[7:0], scrPy);
				end
				actSound: begin
					repeat (48) @(posedge MCLK);
					#3;
					checkSample(steps[i].name, steps[i].expected, sndOut);
				end
				default: ;
			endcase
		end
		@(posedge MCLK);
		#1;
		cs = 1'b0;
		wr = 1'b0;
		$display("test passed");
		$finish;
	end

endmodule

/* all.f */
+incdir+design
design/psgPkg.sv
design/psgBusIf.sv
design/psgClockEnable.sv
design/psgBusDecoder.sv
design/psgToneChip.sv
design/psgMixer.sv
design/psgSound.sv
verif/psgSoundTb.sv
